// File: sim.f
+incdir+sim
hdl/xv_data_pkg.sv
hdl/xv_conf_pkg.sv
hdl/xv_conf_if.sv
hdl/xv_conf_decode.sv
hdl/xv_mul.sv
hdl/xv_alu.sv
hdl/xv_flow_bus.sv
hdl/xv_top.sv
sim/xv_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= xv_tb
SEED      ?= 51419
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; \
		cat $(LOG); \
		if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi; \
		exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/xv_model.svh
logic [DATA_W-1:0]   m_din_a_q;
logic [DATA_W-1:0]   m_din_b_q;
unit_conf_t          m_mul_conf;
unit_conf_t          m_alu_conf;
logic [DATA_W-1:0]   m_mul_a;
logic [DATA_W-1:0]   m_mul_b;
logic [2*DATA_W-1:0] m_prod;
logic [DATA_W-1:0]   m_mul_res;
logic [DATA_W-1:0]   m_alu_a;
logic [DATA_W-1:0]   m_alu_b;
logic [DATA_W-1:0]   m_alu_res;

function automatic logic [2*DATA_W-1:0] sign_extend(input logic [DATA_W-1:0] v);
   return {{DATA_W{v[DATA_W-1]}}, v};
endfunction

// word one bit below the top is the product shifted right by DATA_W-1
function automatic logic [DATA_W-1:0] mul_window(input logic [2*DATA_W-1:0] p,
                                                 input logic [FNS_W-1:0]    fns);
   logic [2*DATA_W-1:0] shifted;
   shifted = p >> (DATA_W - 1);
   case (fns)
      MUL_HI:      return shifted[DATA_W-1:0];
      MUL_DIV2_HI: return p[2*DATA_W-1:DATA_W];
      default:     return p[DATA_W-1:0];
   endcase
endfunction

function automatic logic [DATA_W-1:0] alu_function(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b,
                                                   input logic [FNS_W-1:0]  fns);
   case (fns)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_MAX: return ($signed(a) > $signed(b)) ? a : b;
      ALU_MIN: return ($signed(a) < $signed(b)) ? a : b;
      default: return a;
   endcase
endfunction

task automatic reset_model();
   m_din_a_q  = '0;
   m_din_b_q  = '0;
   m_mul_conf = '0;
   m_alu_conf = '0;
   m_mul_a    = '0;
   m_mul_b    = '0;
   m_prod     = '0;
   m_mul_res  = '0;
   m_alu_a    = '0;
   m_alu_b    = '0;
   m_alu_res  = '0;
endtask

// all next values come from the state before the edge
task automatic step_model();
   logic [DATA_W-1:0] flow [N_SLOTS];
   logic [DATA_W-1:0] nxt_mul_res;
   logic [DATA_W-1:0] nxt_alu_res;
   flow[SLOT_DIN_A] = m_din_a_q;
   flow[SLOT_DIN_B] = m_din_b_q;
   flow[SLOT_MUL]   = m_mul_res;
   flow[SLOT_ALU]   = m_alu_res;
   nxt_mul_res = m_mul_conf.en ? mul_window(m_prod, m_mul_conf.fns) : m_mul_res;
   nxt_alu_res = m_alu_conf.en ? alu_function(m_alu_a, m_alu_b, m_alu_conf.fns) : m_alu_res;
   m_prod    = sign_extend(m_mul_a) * sign_extend(m_mul_b);
   m_mul_a   = flow[m_mul_conf.sela];
   m_mul_b   = flow[m_mul_conf.selb];
   m_alu_a   = flow[m_alu_conf.sela];
   m_alu_b   = flow[m_alu_conf.selb];
   m_mul_res = nxt_mul_res;
   m_alu_res = nxt_alu_res;
   m_din_a_q = din_a;
   m_din_b_q = din_b;
   // new config is seen by the units one edge later
   if (cfg_valid) begin
      if (cfg_addr == UNIT_MUL) begin
         m_mul_conf = cfg_data;
      end else if (cfg_addr == UNIT_ALU) begin
         m_alu_conf = cfg_data;
      end
   end
endtask

// File: sim/xv_tb.sv
`timescale 1ns/10ps

module xv_tb
   import xv_data_pkg::*;
   import xv_conf_pkg::*;
#(
   parameter int SEED = 51419
) ();

   localparam int DATA_W     = 16;
   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 10;
   localparam int N_RESET    = 20;
   localparam int N_MUL      = 200;
   localparam int N_ALU      = 100;
   localparam int N_HOLD     = 40;
   localparam int N_CHAIN    = 200;
   localparam int N_RECONF   = 300;
   localparam int MARGIN     = 200;
   localparam int TOTAL_CYCLES = N_RESET + 3*N_MUL + 8*N_ALU + 3*N_HOLD + N_CHAIN + N_RECONF;

   logic              clk;
   logic              rst;
   logic              cfg_valid;
   logic [UNIT_W-1:0] cfg_addr;
   logic [CONF_W-1:0] cfg_data;
   logic [DATA_W-1:0] din_a;
   logic [DATA_W-1:0] din_b;
   logic [DATA_W-1:0] dout_mul;
   logic [DATA_W-1:0] dout_alu;

   integer            seed;
   int                test_errors;
   int                test_cycles;
   int                pass_count;
   int                fail_count;
   logic [DATA_W-1:0] held_mul;
   logic [DATA_W-1:0] held_alu;
   string             mul_names [3] = '{"mul_lo", "mul_hi", "mul_div2_hi"};
   logic [FNS_W-1:0]  mul_codes [3] = '{MUL_LO, MUL_HI, MUL_DIV2_HI};

   `include "xv_model.svh"

   xv_top #(.DATA_W(DATA_W)) u_dut (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .din_a     (din_a),
      .din_b     (din_b),
      .dout_mul  (dout_mul),
      .dout_alu  (dout_alu)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // one edge: model steps on the edge, outputs are compared 1 ns later
   task automatic clock_cycle(input string name);
      @(posedge clk);
      step_model();
      #1;
      test_cycles++;
      if (dout_mul !== m_mul_res) begin
         $display("error %s dout_mul: expected %h actual %h", name, m_mul_res, dout_mul);
         test_errors++;
      end
      if (dout_alu !== m_alu_res) begin
         $display("error %s dout_alu: expected %h actual %h", name, m_alu_res, dout_alu);
         test_errors++;
      end
      cfg_valid = 1'b0;
      din_a     = DATA_W'($random(seed));
      din_b     = DATA_W'($random(seed));
   endtask

   task automatic run_cycles(input string name, input int n);
      for (int i = 0; i < n; i++) begin
         clock_cycle(name);
      end
   endtask

   task automatic write_cfg(input logic [UNIT_W-1:0] addr, input slot_t sela,
                            input slot_t selb, input logic [FNS_W-1:0] fns,
                            input logic en);
      unit_conf_t c;
      c.sela    = sela;
      c.selb    = selb;
      c.fns     = fns;
      c.en      = en;
      cfg_valid = 1'b1;
      cfg_addr  = addr;
      cfg_data  = c;
   endtask

   task automatic config_unit(input string name, input logic [UNIT_W-1:0] addr,
                              input slot_t sela, input slot_t selb,
                              input logic [FNS_W-1:0] fns, input logic en);
      write_cfg(addr, sela, selb, fns, en);
      clock_cycle(name);
   endtask

   task automatic finish_test(input string name);
      $display("test %-12s %4d cycles  %0d errors", name, test_cycles, test_errors);
      if (test_errors == 0) begin
         pass_count++;
      end else begin
         fail_count++;
      end
      test_errors = 0;
      test_cycles = 0;
   endtask

   // watchdog
   initial begin
      #((RST_CYCLES + TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
      $display("timeout: the tests did not complete in the expected number of cycles");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      cfg_valid   = 1'b0;
      cfg_addr    = '0;
      cfg_data    = '0;
      din_a       = '0;
      din_b       = '0;
      seed        = SEED;
      test_errors = 0;
      test_cycles = 0;
      pass_count  = 0;
      fail_count  = 0;
      reset_model();

      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst   = 1'b0;
      din_a = DATA_W'($random(seed));
      din_b = DATA_W'($random(seed));

      // nothing configured, both units stay disabled
      for (int i = 0; i < N_RESET; i++) begin
         clock_cycle("reset");
         if (dout_mul !== '0) begin
            $display("error reset dout_mul: expected %h actual %h", {DATA_W{1'b0}}, dout_mul);
            test_errors++;
         end
         if (dout_alu !== '0) begin
            $display("error reset dout_alu: expected %h actual %h", {DATA_W{1'b0}}, dout_alu);
            test_errors++;
         end
      end
      finish_test("reset");

      for (int k = 0; k < 3; k++) begin
         config_unit(mul_names[k], UNIT_MUL, SLOT_DIN_A, SLOT_DIN_B, mul_codes[k], 1'b1);
         run_cycles(mul_names[k], N_MUL);
         finish_test(mul_names[k]);
      end

      for (int f = 0; f < 8; f++) begin
         config_unit($sformatf("alu_fn%0d", f), UNIT_ALU, SLOT_DIN_A, SLOT_DIN_B,
                     FNS_W'(f), 1'b1);
         run_cycles($sformatf("alu_fn%0d", f), N_ALU);
         finish_test($sformatf("alu_fn%0d", f));
      end

      config_unit("hold", UNIT_MUL, SLOT_DIN_A, SLOT_DIN_B, MUL_LO, 1'b1);
      config_unit("hold", UNIT_ALU, SLOT_DIN_A, SLOT_DIN_B, ALU_ADD, 1'b1);
      run_cycles("hold", N_HOLD);
      config_unit("hold", UNIT_MUL, SLOT_DIN_A, SLOT_DIN_B, MUL_LO, 1'b0);
      config_unit("hold", UNIT_ALU, SLOT_DIN_A, SLOT_DIN_B, ALU_ADD, 1'b0);
      // both units frozen from here on
      held_mul = m_mul_res;
      held_alu = m_alu_res;
      for (int i = 0; i < N_HOLD; i++) begin
         clock_cycle("hold");
         if (dout_mul !== held_mul) begin
            $display("error hold dout_mul: expected %h actual %h", held_mul, dout_mul);
            test_errors++;
         end
         if (dout_alu !== held_alu) begin
            $display("error hold dout_alu: expected %h actual %h", held_alu, dout_alu);
            test_errors++;
         end
      end
      config_unit("hold", UNIT_MUL, SLOT_DIN_A, SLOT_DIN_B, MUL_LO, 1'b1);
      config_unit("hold", UNIT_ALU, SLOT_DIN_A, SLOT_DIN_B, ALU_ADD, 1'b1);
      run_cycles("hold", N_HOLD);
      finish_test("hold");

      // alu adds din_a to the multiplier slot
      config_unit("chain", UNIT_MUL, SLOT_DIN_A, SLOT_DIN_B, MUL_LO, 1'b1);
      config_unit("chain", UNIT_ALU, SLOT_MUL, SLOT_DIN_A, ALU_ADD, 1'b1);
      run_cycles("chain", N_CHAIN);
      finish_test("chain");

      for (int i = 0; i < N_RECONF; i++) begin
         if (($random(seed) & 7) == 0) begin
            write_cfg(UNIT_W'($random(seed)), SLOT_W'($random(seed)),
                      SLOT_W'($random(seed)), FNS_W'($random(seed)), 1'($random(seed)));
         end
         clock_cycle("reconf");
      end
      finish_test("reconf");

      $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: hdl/xv_top.sv
`timescale 1ns/10ps

module xv_top
   import xv_data_pkg::*;
   import xv_conf_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              cfg_valid,
   input  logic [UNIT_W-1:0] cfg_addr,
   input  logic [CONF_W-1:0] cfg_data,
   input  logic [DATA_W-1:0] din_a,
   input  logic [DATA_W-1:0] din_b,
   output logic [DATA_W-1:0] dout_mul,
   output logic [DATA_W-1:0] dout_alu
);

   unit_conf_t        cfg_conf;
   logic [DATA_W-1:0] flow [N_SLOTS];
   logic [DATA_W-1:0] mul_result;
   logic [DATA_W-1:0] alu_result;

   assign cfg_conf = unit_conf_t'(cfg_data);

   xv_conf_if #(.DATA_W(DATA_W)) conf_if ();

   xv_conf_decode #(.DATA_W(DATA_W)) u_decode (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_conf),
      .conf      (conf_if.decoder)
   );

   xv_flow_bus #(.DATA_W(DATA_W)) u_flow_bus (
      .clk        (clk),
      .rst        (rst),
      .din_a      (din_a),
      .din_b      (din_b),
      .mul_result (mul_result),
      .alu_result (alu_result),
      .flow       (flow)
   );

   xv_mul #(.DATA_W(DATA_W)) u_mul (
      .clk    (clk),
      .rst    (rst),
      .flow   (flow),
      .conf   (conf_if.unit),
      .result (mul_result)
   );

   xv_alu #(.DATA_W(DATA_W)) u_alu (
      .clk    (clk),
      .rst    (rst),
      .flow   (flow),
      .conf   (conf_if.unit),
      .result (alu_result)
   );

   // outputs show the unit slots of the bus
   assign dout_mul = flow[SLOT_MUL];
   assign dout_alu = flow[SLOT_ALU];

endmodule

// File: hdl/xv_flow_bus.sv
`timescale 1ns/10ps

module xv_flow_bus
   import xv_data_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [DATA_W-1:0] din_a,
   input  logic [DATA_W-1:0] din_b,
   input  logic [DATA_W-1:0] mul_result,
   input  logic [DATA_W-1:0] alu_result,
   output logic [DATA_W-1:0] flow [N_SLOTS]
);

   logic [DATA_W-1:0] din_a_q;
   logic [DATA_W-1:0] din_b_q;

   // external inputs get one register stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         din_a_q <= '0;
         din_b_q <= '0;
      end else begin
         din_a_q <= din_a;
         din_b_q <= din_b;
      end
   end

   // slot layout
   assign flow[SLOT_DIN_A] = din_a_q;
   assign flow[SLOT_DIN_B] = din_b_q;
   // unit outputs are already registered inside the units
   assign flow[SLOT_MUL]   = mul_result;
   assign flow[SLOT_ALU]   = alu_result;

endmodule

// File: hdl/xv_alu.sv
`timescale 1ns/10ps

module xv_alu
   import xv_data_pkg::*;
   import xv_conf_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [DATA_W-1:0] flow [N_SLOTS],
   xv_conf_if.unit           conf,
   output logic [DATA_W-1:0] result
);

   logic signed [DATA_W-1:0] op_a;
   logic signed [DATA_W-1:0] op_b;
   logic signed [DATA_W-1:0] op_a_q;
   logic signed [DATA_W-1:0] op_b_q;
   logic        [DATA_W-1:0] res;

   assign op_a = flow[conf.alu_conf.sela];
   assign op_b = flow[conf.alu_conf.selb];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_a_q <= '0;
         op_b_q <= '0;
      end else begin
         op_a_q <= op_a;
         op_b_q <= op_b;
      end
   end

   // add and sub simply wrap, no flags
   always_comb begin
      case (conf.alu_conf.fns)
         ALU_ADD: res = op_a_q + op_b_q;
         ALU_SUB: res = op_a_q - op_b_q;
         ALU_AND: res = op_a_q & op_b_q;
         ALU_OR:  res = op_a_q | op_b_q;
         ALU_XOR: res = op_a_q ^ op_b_q;
         // signed compares
         ALU_MAX: res = (op_a_q > op_b_q) ? op_a_q : op_b_q;
         ALU_MIN: res = (op_a_q < op_b_q) ? op_a_q : op_b_q;
         // code 7 passes a through
         default: res = op_a_q;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (conf.alu_conf.en) begin
         result <= res;
      end
   end

endmodule

// File: hdl/xv_mul.sv
`timescale 1ns/10ps

module xv_mul
   import xv_data_pkg::*;
   import xv_conf_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [DATA_W-1:0] flow [N_SLOTS],
   xv_conf_if.unit           conf,
   output logic [DATA_W-1:0] result
);

   logic signed [DATA_W-1:0]   op_a;
   logic signed [DATA_W-1:0]   op_b;
   logic signed [DATA_W-1:0]   op_a_q;
   logic signed [DATA_W-1:0]   op_b_q;
   logic signed [2*DATA_W-1:0] prod_q;
   logic        [DATA_W-1:0]   res;

   // operand select from the bus
   assign op_a = flow[conf.mul_conf.sela];
   assign op_b = flow[conf.mul_conf.selb];

   // operand and product stages run regardless of en
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_a_q <= '0;
         op_b_q <= '0;
         prod_q <= '0;
      end else begin
         op_a_q <= op_a;
         op_b_q <= op_b;
         prod_q <= (2*DATA_W)'(op_a_q) * (2*DATA_W)'(op_b_q);
      end
   end

   // pick the output window of the full product
   always_comb begin
      case (conf.mul_conf.fns)
         MUL_HI:      res = prod_q[2*DATA_W-2 -: DATA_W];
         MUL_DIV2_HI: res = prod_q[2*DATA_W-1 -: DATA_W];
         default:     res = prod_q[DATA_W-1:0];
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (conf.mul_conf.en) begin
         result <= res;
      end
   end

endmodule

// File: hdl/xv_conf_decode.sv
`timescale 1ns/10ps

module xv_conf_decode
   import xv_conf_pkg::*;
#(
   parameter int DATA_W = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              cfg_valid,
   input  logic [UNIT_W-1:0] cfg_addr,
   input  unit_conf_t        cfg_data,
   xv_conf_if.decoder        conf
);

   unit_conf_t mul_conf_q;
   unit_conf_t alu_conf_q;

   // after reset both units read slot 0, function 0, disabled
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mul_conf_q <= '0;
         alu_conf_q <= '0;
      end else if (cfg_valid) begin
         case (cfg_addr)
            UNIT_MUL: mul_conf_q <= cfg_data;
            UNIT_ALU: alu_conf_q <= cfg_data;
            // unused addresses drop the write
            default: ;
         endcase
      end
   end

   assign conf.mul_conf = mul_conf_q;
   assign conf.alu_conf = alu_conf_q;

endmodule

// File: hdl/xv_conf_if.sv
`timescale 1ns/10ps

interface xv_conf_if
   import xv_conf_pkg::*;
#(
   parameter int DATA_W = 16
) ();

   // decoded configuration, one word per unit
   unit_conf_t mul_conf;
   unit_conf_t alu_conf;

   modport decoder (
      output mul_conf,
      output alu_conf
   );

   modport unit (
      input mul_conf,
      input alu_conf
   );

endinterface

// File: hdl/xv_conf_pkg.sv
package xv_conf_pkg;

   import xv_data_pkg::*;

   // field widths
   localparam int FNS_W  = 3;
   localparam int UNIT_W = 1;

   // one configuration word per functional unit
   // sela sits in the top bits, en in bit 0
   typedef struct packed {
      slot_t            sela;
      slot_t            selb;
      logic [FNS_W-1:0] fns;
      logic             en;
   } unit_conf_t;

   localparam int CONF_W = $bits(unit_conf_t);

   // unit addresses
   localparam logic [UNIT_W-1:0] UNIT_MUL = 1'd0;
   localparam logic [UNIT_W-1:0] UNIT_ALU = 1'd1;

   // multiplier output windows
   localparam logic [FNS_W-1:0] MUL_LO      = 3'd0;
   localparam logic [FNS_W-1:0] MUL_HI      = 3'd1;
   localparam logic [FNS_W-1:0] MUL_DIV2_HI = 3'd2;

   // alu functions, code 7 passes operand a
   localparam logic [FNS_W-1:0] ALU_ADD = 3'd0;
   localparam logic [FNS_W-1:0] ALU_SUB = 3'd1;
   localparam logic [FNS_W-1:0] ALU_AND = 3'd2;
   localparam logic [FNS_W-1:0] ALU_OR  = 3'd3;
   localparam logic [FNS_W-1:0] ALU_XOR = 3'd4;
   localparam logic [FNS_W-1:0] ALU_MAX = 3'd5;
   localparam logic [FNS_W-1:0] ALU_MIN = 3'd6;

endpackage

// File: hdl/xv_data_pkg.sv
package xv_data_pkg;

   // flow bus geometry
   localparam int N_SLOTS = 4;
   localparam int SLOT_W  = 2;

   // slot index as carried in a unit configuration
   typedef logic [SLOT_W-1:0] slot_t;

   // fixed slot layout of the flow bus
   // external inputs first, then the unit outputs
   localparam slot_t SLOT_DIN_A = 2'd0;
   localparam slot_t SLOT_DIN_B = 2'd1;
   localparam slot_t SLOT_MUL   = 2'd2;
   localparam slot_t SLOT_ALU   = 2'd3;

endpackage
